/* source/config_consts.svh */
`ifndef CONFIG_CONSTS_SVH
`define CONFIG_CONSTS_SVH

// host word and register file geometry
`define CONF_W 16
`define REG_N 32
`define REG_ADDR_W 5
`define HOST_W 24

// configuration field widths
`define SF_FILTS_W 10
`define SF_STATE_W 27
`define SG_GENS_W 8
`define SG_PERIOD_W 16
`define SG_TAG_W 11
`define TM_TIME_W 48
`define TM_UNIT_W 16
`define SG_EN_W 256

// program entry is gens + two periods + tag
`define SG_ENTRY_W 51
`define SG_CHUNKS 4

// number of registers spanned by multi-register fields
`define SF_STATE_CHUNKS 2
`define SG_EN_CHUNKS 16
`define TM_TIME_CHUNKS 3

// register indices
`define SF_FILTS_IDX 0
`define SF_INC_IDX 1
`define SF_DECAY_IDX 3
`define SG_GENS_IDX 5
`define SG_EN_IDX 6
`define TM_UNIT_IDX 22
`define TM_ELAPSED_IDX 23
`define TM_HB_IDX 26
`define TM_RESET_IDX 29
`define TS_TAGS_IDX 30

// non-zero reset values
`define SF_INC_RST 1
`define TM_UNIT_RST 5000
`define TM_HB_RST 10
`define TS_TAGS_RST 1

`endif

/* source/configPkg.sv */
`default_nettype none

`include "config_consts.svh"

package configPkg;

  ////////////////////////////////////////////////////////////
  // host side words

  // kind bit set: register write
  typedef struct packed {
    logic                   kind;
    logic [1:0]             rsvd;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`CONF_W-1:0]     data;
  } hostRegWrite_t;

  // kind bit clear: one 16-bit chunk for the program stream
  typedef struct packed {
    logic               kind;
    logic [6:0]         rsvd;
    logic [`CONF_W-1:0] data;
  } hostChunk_t;

  typedef union packed {
    hostRegWrite_t regWrite;
    hostChunk_t    chunk;
  } hostWord_t;

  typedef struct packed {
    logic                   strobe;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`CONF_W-1:0]     data;
  } regWrite_t;

  typedef logic [`REG_N-1:0][`CONF_W-1:0] regArray_t;

  ////////////////////////////////////////////////////////////
  // configuration views of the register file

  typedef struct packed {
    logic [`SF_FILTS_W-1:0] filtsUsed;
    logic [`SF_STATE_W-1:0] incrementConstant;
    logic [`SF_STATE_W-1:0] decayConstant;
  } spikeFilterConf_t;

  typedef struct packed {
    logic [`SG_GENS_W-1:0] gensUsed;
    logic [`SG_EN_W-1:0]   gensEn;
  } spikeGenConf_t;

  typedef struct packed {
    logic [`TM_UNIT_W-1:0] unitLen;
    logic [`TM_TIME_W-1:0] timeElapsed;
    logic [`TM_TIME_W-1:0] sendHbEvery;
    logic                  resetTime;
  } timeMgrConf_t;

  typedef struct packed {
    logic reportTags;
  } tagSplitConf_t;

  // generator program memory entry, msb first
  typedef struct packed {
    logic [`SG_GENS_W-1:0]   genIdx;
    logic [`SG_PERIOD_W-1:0] period;
    logic [`SG_PERIOD_W-1:0] ticks;
    logic [`SG_TAG_W-1:0]    tag;
  } sgProgramEntry_t;

endpackage

`default_nettype wire

/* source/configParser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "config_consts.svh"

module configParser (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                hostValid,
  input  wire configPkg::hostWord_t hostWord,
  input  wire logic                chunkReady,
  output logic                     hostReady,
  output configPkg::regWrite_t     regWrite,
  output logic                     chunkValid,
  output logic [`CONF_W-1:0]       chunkData
);

  logic                   accept;
  logic                   writeStrobe;
  logic [`REG_ADDR_W-1:0] writeAddr;
  logic [`CONF_W-1:0]     writeData;

  // stall everything while the chunk stage is stuck, keeps host order
  assign hostReady = !chunkValid || chunkReady;
  assign accept    = hostValid && hostReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      writeStrobe <= 1'b0;
      chunkValid  <= 1'b0;
    end else begin
      writeStrobe <= accept && hostWord.regWrite.kind;
      if (accept && !hostWord.chunk.kind) begin
        chunkValid <= 1'b1;
      end else if (chunkReady) begin
        chunkValid <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept && hostWord.regWrite.kind) begin
      writeAddr <= hostWord.regWrite.addr;
      writeData <= hostWord.regWrite.data;
    end
    if (accept && !hostWord.chunk.kind) begin
      chunkData <= hostWord.chunk.data;
    end
  end

  assign regWrite = '{strobe: writeStrobe, addr: writeAddr, data: writeData};

  // a stalled chunk must not change under the deserializer
  chunkHeld: assert property (@(posedge clk) disable iff (reset)
    chunkValid && !chunkReady |=> chunkValid && $stable(chunkData));

endmodule

`default_nettype wire

/* source/configRegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

module configRegisterFile (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire configPkg::regWrite_t regWrite,
  input  wire configPkg::regArray_t resetValues,
  output configPkg::regArray_t      regs
);

  ////////////////////////////////////////////////////////////
  // storage

  // reset values come from the mapper's table
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= resetValues;
    end else if (regWrite.strobe) begin
      regs[regWrite.addr] <= regWrite.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks

  // parser must come out of reset with its strobe cleared
  noWriteInReset: assert property (@(posedge clk)
    reset |=> !regWrite.strobe);

endmodule

`default_nettype wire

/* source/wordDeserializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "config_consts.svh"

module wordDeserializer (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  chunkValid,
  input  wire logic [`CONF_W-1:0]    chunkData,
  input  wire logic                  entryReady,
  output logic                       chunkReady,
  output logic                       entryValid,
  output configPkg::sgProgramEntry_t entry
);

  logic [1:0]                         chunkCount;
  logic [`CONF_W*`SG_CHUNKS-1:0]      shiftBuf;
  logic                               chunkTaken;

  // one entry at a time, no assembly while an entry waits
  assign chunkReady = !entryValid;
  assign chunkTaken = chunkValid && chunkReady;

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (reset) begin
      chunkCount <= '0;
      entryValid <= 1'b0;
    end else begin
      if (chunkTaken) begin
        chunkCount <= chunkCount + 2'd1;
        if (chunkCount == 2'(`SG_CHUNKS - 1)) begin
          entryValid <= 1'b1;
        end
      end else if (entryValid && entryReady) begin
        entryValid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // data path

  // new chunks enter at the top and move down, so chunk one lands in 15:0
  always_ff @(posedge clk) begin
    if (chunkTaken) begin
      shiftBuf <= {chunkData, shiftBuf[`CONF_W*`SG_CHUNKS-1:`CONF_W]};
    end
  end

  // upper bits of the last chunk fall off here
  assign entry = configPkg::sgProgramEntry_t'(shiftBuf[`SG_ENTRY_W-1:0]);

  entryHeld: assert property (@(posedge clk) disable iff (reset)
    entryValid && !entryReady |=> entryValid && $stable(entry));

endmodule

`default_nettype wire

/* source/configMapper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "config_consts.svh"

module configMapper (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire configPkg::regArray_t  regs,
  input  wire logic                  chunkValid,
  input  wire logic [`CONF_W-1:0]    chunkData,
  input  wire logic                  sgProgramReady,
  output configPkg::regArray_t       resetValues,
  output configPkg::spikeFilterConf_t sfConf,
  output configPkg::spikeGenConf_t   sgConf,
  output configPkg::timeMgrConf_t    tmConf,
  output configPkg::tagSplitConf_t   tsConf,
  output logic                       chunkReady,
  output logic                       sgProgramValid,
  output configPkg::sgProgramEntry_t sgProgram
);

  logic [`SF_STATE_CHUNKS*`CONF_W-1:0] incWide;
  logic [`SF_STATE_CHUNKS*`CONF_W-1:0] decayWide;

  ////////////////////////////////////////////////////////////
  // register slicing

  // lower index holds the low half
  assign incWide   = regs[`SF_INC_IDX +: `SF_STATE_CHUNKS];
  assign decayWide = regs[`SF_DECAY_IDX +: `SF_STATE_CHUNKS];

  assign sfConf.filtsUsed         = regs[`SF_FILTS_IDX][`SF_FILTS_W-1:0];
  assign sfConf.incrementConstant = incWide[`SF_STATE_W-1:0];
  assign sfConf.decayConstant     = decayWide[`SF_STATE_W-1:0];

  assign sgConf.gensUsed = regs[`SG_GENS_IDX][`SG_GENS_W-1:0];
  assign sgConf.gensEn   = regs[`SG_EN_IDX +: `SG_EN_CHUNKS];

  assign tmConf.unitLen     = regs[`TM_UNIT_IDX];
  assign tmConf.timeElapsed = regs[`TM_ELAPSED_IDX +: `TM_TIME_CHUNKS];
  assign tmConf.sendHbEvery = regs[`TM_HB_IDX +: `TM_TIME_CHUNKS];
  assign tmConf.resetTime   = regs[`TM_RESET_IDX][0];

  // register 31 is spare and maps to nothing
  assign tsConf.reportTags = regs[`TS_TAGS_IDX][0];

  ////////////////////////////////////////////////////////////
  // reset table

  always_comb begin
    resetValues = '0;
    // filters start in decay mode with unit increment
    resetValues[`SF_INC_IDX] = `CONF_W'(`SF_INC_RST);
    // 25 us time unit at 200 MHz
    resetValues[`TM_UNIT_IDX] = `CONF_W'(`TM_UNIT_RST);
    // heartbeat every 10 time units
    resetValues[`TM_HB_IDX] = `CONF_W'(`TM_HB_RST);
    resetValues[`TS_TAGS_IDX] = `CONF_W'(`TS_TAGS_RST);
  end

  ////////////////////////////////////////////////////////////
  // program stream

  wordDeserializer sgDeserializer (
    .clk        (clk),
    .reset      (reset),
    .chunkValid (chunkValid),
    .chunkData  (chunkData),
    .entryReady (sgProgramReady),
    .chunkReady (chunkReady),
    .entryValid (sgProgramValid),
    .entry      (sgProgram)
  );

endmodule

`default_nettype wire

/* source/configTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "config_consts.svh"

module configTop (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   hostValid,
  input  wire configPkg::hostWord_t   hostWord,
  input  wire logic                   sgProgramReady,
  output logic                        hostReady,
  output configPkg::spikeFilterConf_t sfConf,
  output configPkg::spikeGenConf_t    sgConf,
  output configPkg::timeMgrConf_t     tmConf,
  output configPkg::tagSplitConf_t    tsConf,
  output logic                        sgProgramValid,
  output configPkg::sgProgramEntry_t  sgProgram
);

  configPkg::regWrite_t regWrite;
  configPkg::regArray_t regs;
  configPkg::regArray_t resetValues;
  logic                 chunkValid;
  logic [`CONF_W-1:0]   chunkData;
  logic                 chunkReady;

  // host words split into register writes and stream chunks
  configParser parser (
    .clk        (clk),
    .reset      (reset),
    .hostValid  (hostValid),
    .hostWord   (hostWord),
    .chunkReady (chunkReady),
    .hostReady  (hostReady),
    .regWrite   (regWrite),
    .chunkValid (chunkValid),
    .chunkData  (chunkData)
  );

  configRegisterFile registerFile (
    .clk         (clk),
    .reset       (reset),
    .regWrite    (regWrite),
    .resetValues (resetValues),
    .regs        (regs)
  );

  configMapper mapper (
    .clk            (clk),
    .reset          (reset),
    .regs           (regs),
    .chunkValid     (chunkValid),
    .chunkData      (chunkData),
    .sgProgramReady (sgProgramReady),
    .resetValues    (resetValues),
    .sfConf         (sfConf),
    .sgConf         (sgConf),
    .tmConf         (tmConf),
    .tsConf         (tsConf),
    .chunkReady     (chunkReady),
    .sgProgramValid (sgProgramValid),
    .sgProgram      (sgProgram)
  );

endmodule

`default_nettype wire

/* test/configTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module configTopTb;

  // roughly four times the summed length of all tests
  localparam int cycleLimit = 2000;

  logic                        clk;
  logic                        reset;
  logic                        hostValid;
  configPkg::hostWord_t        hostWord;
  logic                        sgProgramReady;
  logic                        hostReady;
  configPkg::spikeFilterConf_t sfConf;
  configPkg::spikeGenConf_t    sgConf;
  configPkg::timeMgrConf_t     tmConf;
  configPkg::tagSplitConf_t    tsConf;
  logic                        sgProgramValid;
  configPkg::sgProgramEntry_t  sgProgram;

  string                      currentTest;
  int                         cycleCount;
  logic [15:0]                shadowRegs [0:31];
  logic [50:0]                expectedQ [$];
  configPkg::sgProgramEntry_t receivedQ [$];

  configTop uut (
    .clk            (clk),
    .reset          (reset),
    .hostValid      (hostValid),
    .hostWord       (hostWord),
    .sgProgramReady (sgProgramReady),
    .hostReady      (hostReady),
    .sfConf         (sfConf),
    .sgConf         (sgConf),
    .tmConf         (tmConf),
    .tsConf         (tsConf),
    .sgProgramValid (sgProgramValid),
    .sgProgram      (sgProgram)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // entries leave on a rising edge with valid and ready both high
  always @(posedge clk) begin
    if (!reset && sgProgramValid && sgProgramReady) begin
      receivedQ.push_back(sgProgram);
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the tests did not finish within %0d clock cycles", cycleLimit);
      $display("Regression failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic checkValue(input string what, input logic [255:0] expected,
                            input logic [255:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: %s expected %0h actual %0h", currentTest, what, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic configPkg::hostWord_t writeWord(input logic [4:0] addr,
                                                     input logic [15:0] data);
    configPkg::hostWord_t w;
    w = {1'b1, 2'b00, addr, data};
    return w;
  endfunction

  function automatic configPkg::hostWord_t chunkWord(input logic [15:0] data);
    configPkg::hostWord_t w;
    w = {1'b0, 7'd0, data};
    return w;
  endfunction

  // chunk one in 15:0, low 3 bits of chunk four in 50:48
  function automatic logic [50:0] placeChunks(input logic [63:0] chunks);
    return {chunks[50:48], chunks[47:32], chunks[31:16], chunks[15:0]};
  endfunction

  // all drive tasks start and end on a falling edge
  task automatic offerWord(input configPkg::hostWord_t w);
    hostValid = 1'b1;
    hostWord  = w;
  endtask

  task automatic waitAccept;
    while (!hostReady) begin
      @(negedge clk);
    end
    @(posedge clk);
    @(negedge clk);
    hostValid = 1'b0;
  endtask

  task automatic sendWord(input configPkg::hostWord_t w);
    offerWord(w);
    waitAccept();
  endtask

  task automatic writeReg(input logic [4:0] addr, input logic [15:0] data);
    sendWord(writeWord(addr, data));
    shadowRegs[addr] = data;
    // parser stage, then the register file
    repeat (2) @(negedge clk);
  endtask

  task automatic sendEntry(input logic [63:0] chunks);
    expectedQ.push_back(placeChunks(chunks));
    for (int i = 0; i < 4; i++) begin
      sendWord(chunkWord(chunks[16*i +: 16]));
    end
  endtask

  task automatic checkEntries;
    logic [50:0]                e;
    configPkg::sgProgramEntry_t r;
    while (expectedQ.size() > 0) begin
      while (receivedQ.size() == 0) begin
        @(negedge clk);
      end
      e = expectedQ.pop_front();
      r = receivedQ.pop_front();
      checkValue("genIdx", e[50:43], r.genIdx);
      checkValue("period", e[42:27], r.period);
      checkValue("ticks", e[26:11], r.ticks);
      checkValue("tag", e[10:0], r.tag);
    end
  endtask

  task automatic checkConfig;
    logic [31:0]  pair;
    logic [47:0]  triple;
    logic [255:0] enables;
    checkValue("filtsUsed", shadowRegs[0][9:0], sfConf.filtsUsed);
    pair = {shadowRegs[2], shadowRegs[1]};
    checkValue("incrementConstant", pair[26:0], sfConf.incrementConstant);
    pair = {shadowRegs[4], shadowRegs[3]};
    checkValue("decayConstant", pair[26:0], sfConf.decayConstant);
    checkValue("gensUsed", shadowRegs[5][7:0], sgConf.gensUsed);
    for (int i = 0; i < 16; i++) begin
      enables[16*i +: 16] = shadowRegs[6 + i];
    end
    checkValue("gensEn", enables, sgConf.gensEn);
    checkValue("unitLen", shadowRegs[22], tmConf.unitLen);
    triple = {shadowRegs[25], shadowRegs[24], shadowRegs[23]};
    checkValue("timeElapsed", triple, tmConf.timeElapsed);
    triple = {shadowRegs[28], shadowRegs[27], shadowRegs[26]};
    checkValue("sendHbEvery", triple, tmConf.sendHbEvery);
    checkValue("resetTime", shadowRegs[29][0], tmConf.resetTime);
    checkValue("reportTags", shadowRegs[30][0], tsConf.reportTags);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic resetDefaults;
    currentTest = "resetDefaults";
    foreach (shadowRegs[i]) begin
      shadowRegs[i] = '0;
    end
    shadowRegs[1]  = 16'd1;
    shadowRegs[22] = 16'd5000;
    shadowRegs[26] = 16'd10;
    shadowRegs[30] = 16'd1;
    checkValue("hostReady", 1, hostReady);
    checkValue("sgProgramValid", 0, sgProgramValid);
    checkConfig();
  endtask

  task automatic registerWrites;
    currentTest = "registerWrites";
    for (int a = 0; a < 31; a++) begin
      writeReg(5'(a), 16'($urandom));
      checkConfig();
    end
    // no field may move on a spare register write
    writeReg(5'd31, 16'($urandom));
    checkConfig();
  endtask

  task automatic programAssembly;
    currentTest = "programAssembly";
    sgProgramReady = 1'b1;
    repeat (8) begin
      sendEntry({$urandom, $urandom});
    end
    checkEntries();
  endtask

  task automatic backPressure;
    logic sawStall;
    currentTest = "backPressure";
    sawStall = 1'b0;
    sgProgramReady = 1'b0;
    fork
      begin
        repeat (4) sendEntry({$urandom, $urandom});
      end
      begin
        // long enough for the parser stage to fill behind the first entry
        repeat (12) begin
          @(negedge clk);
          if (!hostReady) begin
            sawStall = 1'b1;
          end
        end
        while (receivedQ.size() < 4) begin
          @(negedge clk);
          sgProgramReady = 1'($urandom);
        end
      end
    join
    sgProgramReady = 1'b1;
    checkValue("hostReady fell", 1, sawStall);
    checkEntries();
  endtask

  task automatic interleavedOrder;
    logic [63:0] chunks;
    logic [15:0] newUnit;
    currentTest = "interleavedOrder";
    sgProgramReady = 1'b0;
    sendEntry({$urandom, $urandom});
    chunks = {$urandom, $urandom};
    newUnit = 16'($urandom);
    expectedQ.push_back(placeChunks(chunks));
    // first chunk of the next entry parks in the parser stage
    sendWord(chunkWord(chunks[15:0]));
    offerWord(writeWord(5'd22, newUnit));
    repeat (4) begin
      @(negedge clk);
      checkValue("hostReady while stalled", 0, hostReady);
      checkValue("unitLen while stalled", shadowRegs[22], tmConf.unitLen);
    end
    sgProgramReady = 1'b1;
    waitAccept();
    shadowRegs[22] = newUnit;
    repeat (2) @(negedge clk);
    checkConfig();
    for (int i = 1; i < 4; i++) begin
      sendWord(chunkWord(chunks[16*i +: 16]));
    end
    checkEntries();
  endtask

  initial begin
    void'($urandom(73));
    reset = 1'b1;
    hostValid = 1'b0;
    hostWord = '0;
    sgProgramReady = 1'b1;
    cycleCount = 0;
    currentTest = "reset";
    repeat (16) @(negedge clk);
    reset = 1'b0;
    resetDefaults();
    registerWrites();
    programAssembly();
    backPressure();
    interleavedOrder();
    currentTest = "endOfRun";
    repeat (4) @(negedge clk);
    checkValue("extra entries", 0, receivedQ.size());
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* configTop.f */
+incdir+source
source/configPkg.sv
source/configParser.sv
source/configRegisterFile.sv
source/wordDeserializer.sv
source/configMapper.sv
source/configTop.sv
test/configTopTb.sv

/* Bender.yml */
package:
  name: config_top

export_include_dirs:
  - source

sources:
  - source/configPkg.sv
  - source/configParser.sv
  - source/configRegisterFile.sv
  - source/wordDeserializer.sv
  - source/configMapper.sv
  - source/configTop.sv
  - target: test
    files:
      - test/configTopTb.sv
